//--- sources.f
hw/cpuPkg.sv
hw/aluUnit.sv
hw/regFile.sv
hw/controlDecoder.sv
hw/coreSequencer.sv
hw/mipsSubsystem.sv
test/isaModel.sv
test/tbMipsSubsystem.sv

//--- runSim.sh
#!/bin/sh
# builds the testbench with Verilator and runs it
# the exit status is nonzero when the build fails or a check fails
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
    --top-module tbMipsSubsystem \
    -f sources.f \
    -Mdir obj_dir &&
./obj_dir/VtbMipsSubsystem || exit 1

//--- test/tbMipsSubsystem.sv
//============================================================================
// random program checked against isaModel plus a zero wait rerun of the stores
// memories decode address bits 9:2 so execution wraps
//============================================================================
`timescale 1ns/1ps

module tbMipsSubsystem;
    import cpuPkg::*;
    import isaModel::*;

    localparam wordT ResetVector = 32'h0000_0040;
    localparam int   NumInstr    = 2000;
    localparam int   Timeout     = 100;        // cycles per wait

    logic clk;
    logic rstN;
    logic iCyc;
    logic iStb;
    wordT iAdr;
    wordT iDatIn;
    logic iAck;
    logic dCyc;
    logic dStb;
    logic dWe;
    wordT dAdr;
    wordT dDatOut;
    wordT dDatIn;
    logic dAck;
    wordT traceAdr [$];         // stores of the first run
    wordT traceDat [$];
    int   storeCount;

    mipsSubsystem #(.ResetVector(ResetVector)) i_mipsSubsystem (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;       // 8 ns period

    task automatic stopRun(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic failValue(input string name, input wordT got, input wordT exp);
        stopRun($sformatf("Fail at %0t: %s is %h, expected %h", $time, name, got, exp));
    endtask

    task automatic insertWaits(input bit randomWaits);
        wordT r;
        if (randomWaits) begin
            r = $random(seed);
            repeat (r[1:0]) @(negedge clk);     // 0 to 3 wait states
        end
    endtask

    task automatic applyReset();
        rstN = 1'b0;
        iAck = 1'b0;
        dAck = 1'b0;
        repeat (8) begin
            @(negedge clk);
            assert (!iCyc && !iStb && !dCyc && !dStb && !dWe)
                else stopRun("a bus strobe was high during reset");
        end
        rstN = 1'b1;
        @(negedge clk);         // one edge with reset released
        assert (!dCyc && !dStb) else stopRun("a data strobe was high after reset release");
        assert (iCyc && iStb) else stopRun("first fetch did not start right after reset");
    endtask

    // sampled at falling edges where registered outputs are stable
    task automatic waitFetch();
        int n;
        n = 0;
        while (!iStb) begin
            assert (!dCyc) else failValue("dCyc", {31'd0, dCyc}, 32'd0);   // stray data cycle
            assert (n < Timeout) else stopRun("no instruction fetch within 100 cycles");
            n++;
            @(negedge clk);
        end
        assert (iCyc) else stopRun("iStb high without iCyc");
    endtask

    task automatic serveFetch(input wordT instr, input bit randomWaits);
        wordT adr;
        adr = iAdr;
        insertWaits(randomWaits);
        assert (iStb) else stopRun("instruction strobe dropped before ack");
        assert (iAdr == adr) else failValue("iAdr", iAdr, adr);     // held while waiting
        iAck   = 1'b1;
        iDatIn = instr;
        @(negedge clk);
        iAck   = 1'b0;
        iDatIn = '0;
    endtask

    task automatic serveData(input logic isStore, input wordT addr, input wordT data,
                             input bit randomWaits, input bit replay);
        int   n;
        wordT heldAdr;
        n = 0;
        while (!dStb) begin
            assert (!iCyc) else stopRun("instruction fetch started before the data access");
            assert (n < Timeout) else stopRun("no data access within 100 cycles");
            n++;
            @(negedge clk);
        end
        assert (dCyc) else stopRun("dStb high without dCyc");
        assert (dWe == isStore) else failValue("dWe", {31'd0, dWe}, {31'd0, isStore});
        if (isStore && replay) begin
            assert (dAdr == traceAdr[storeCount])
                else failValue("dAdr", dAdr, traceAdr[storeCount]);
            assert (dDatOut == traceDat[storeCount])
                else failValue("dDatOut", dDatOut, traceDat[storeCount]);
        end else begin
            assert (dAdr == addr) else failValue("dAdr", dAdr, addr);
            if (isStore) begin
                assert (dDatOut == data) else failValue("dDatOut", dDatOut, data);
                traceAdr.push_back(dAdr);
                traceDat.push_back(dDatOut);
            end
        end
        if (isStore) begin
            storeCount++;
        end
        heldAdr = dAdr;
        insertWaits(randomWaits);
        assert (dStb && dAdr == heldAdr) else stopRun("data access changed before ack");
        dAck   = 1'b1;
        dDatIn = isStore ? '0 : data;   // load data from the model memory
        @(negedge clk);
        dAck   = 1'b0;
        dDatIn = '0;
    endtask

    task automatic runProgram(input bit randomWaits, input bit replay);
        wordT instr;
        logic isMem;
        logic isStore;
        wordT addr;
        wordT data;
        int   regIdx;
        storeCount = 0;
        resetModel(ResetVector);
        applyReset();
        waitFetch();
        assert (iAdr == ResetVector) else failValue("iAdr", iAdr, ResetVector);
        for (int k = 0; k < NumInstr + 31; k++) begin
            waitFetch();
            assert (iAdr == modelPc) else failValue("iAdr", iAdr, modelPc);
            if (k < NumInstr) begin
                instr = imem[iAdr[9:2]];
            end else begin
                regIdx = k - NumInstr + 1;      // dump r1 to r31
                instr  = {OpSw, 5'd0, regIdx[4:0], 9'd0, regIdx[4:0], 2'b00};
            end
            serveFetch(instr, randomWaits);
            stepModel(instr, isMem, isStore, addr, data);
            if (isMem) begin
                serveData(isStore, addr, data, randomWaits, replay);
            end
        end
    endtask

    initial begin
        rstN   = 1'b0;
        iAck   = 1'b0;
        iDatIn = '0;
        dAck   = 1'b0;
        dDatIn = '0;
        genProgram(32'h4400);
        runProgram(1'b1, 1'b0);     // random wait states
        runProgram(1'b0, 1'b1);     // every ack at once
        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- test/isaModel.sv
//============================================================================
// instruction level model, no delay slot, memories decode address bits 9:2
//============================================================================
package isaModel;
    import cpuPkg::*;

    int   seed;                 // program and wait state draws
    wordT imem      [256];      // program image
    wordT dmemInit  [256];      // data image at the start of each run
    wordT dmem      [256];
    wordT modelRegs [32];
    wordT modelPc;

    function automatic wordT randomInstr();
        wordT r;
        wordT f;
        r = $random(seed);
        f = $random(seed);
        case (f[3:0])
            4'd0, 4'd1: return {OpLw, 5'd0, r[20:16], 6'd0, r[7:0], 2'b00};   // r0 base
            4'd2, 4'd3: return {OpSw, 5'd0, r[20:16], 6'd0, r[7:0], 2'b00};
            4'd4:       return {OpJ, r[25:0]};
            4'd5:       return {OpJal, r[25:0]};
            4'd6:       return {OpBne, r[25:0]};                // random offset
            4'd9:       return {OpRType, r[25:21], 15'd0, FnJr};
            4'd10:      return {OpRType, r[25:11], 5'd0, FnAdd};
            4'd11:      return {OpRType, r[25:11], 5'd0, FnSub};
            4'd12:      return {OpRType, r[25:11], 5'd0, FnSlt};
            4'd13:      return {6'h0F, r[25:0]};                // lui, not in subset
            4'd14:      return {OpRType, r[25:6], 6'h25};       // or, not in subset
            default:    return {OpXori, r[25:0]};
        endcase
    endfunction

    function automatic void genProgram(input int seedValue);
        seed = seedValue;
        for (int i = 0; i < 256; i++) begin
            imem[i] = randomInstr();
        end
        for (int i = 0; i < 256; i++) begin
            dmemInit[i] = $random(seed);    // random word per address
        end
    endfunction

    function automatic void resetModel(input wordT resetPc);
        modelPc = resetPc;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i] = dmemInit[i];
        end
    endfunction

    function automatic void writeReg(input regAddrT idx, input wordT value);
        if (idx != 5'd0) begin
            modelRegs[idx] = value;     // r0 stays zero
        end
    endfunction

    // one instruction, returns the data access it should make
    function automatic void stepModel(input wordT instr, output logic isMem,
                                      output logic isStore, output wordT addr,
                                      output wordT data);
        wordT a;
        wordT b;
        wordT sext;
        wordT pc4;
        wordT nextPc;
        a       = modelRegs[instr[25:21]];
        b       = modelRegs[instr[20:16]];
        sext    = {{16{instr[15]}}, instr[15:0]};
        pc4     = modelPc + 32'd4;
        nextPc  = pc4;
        isMem   = 1'b0;
        isStore = 1'b0;
        addr    = '0;
        data    = '0;
        case (instr[31:26])
            OpLw: begin
                isMem = 1'b1;
                addr  = a + sext;
                data  = dmem[addr[9:2]];
                writeReg(instr[20:16], data);
            end
            OpSw: begin
                isMem   = 1'b1;
                isStore = 1'b1;
                addr    = a + sext;
                data    = b;
                dmem[addr[9:2]] = b;
            end
            OpJ:    nextPc = {pc4[31:28], instr[25:0], 2'b00};
            OpJal: begin
                nextPc = {pc4[31:28], instr[25:0], 2'b00};
                writeReg(5'd31, pc4);                           // link
            end
            OpBne:  nextPc = (a != b) ? pc4 + {sext[29:0], 2'b00} : pc4;
            OpXori: writeReg(instr[20:16], a ^ {16'd0, instr[15:0]});
            OpRType: begin
                case (instr[5:0])
                    FnJr:  nextPc = {a[31:2], 2'b00};
                    FnAdd: writeReg(instr[15:11], a + b);
                    FnSub: writeReg(instr[15:11], a - b);
                    FnSlt: writeReg(instr[15:11], ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
                    default: ;                                  // no-op
                endcase
            end
            default: ;                                          // no-op
        endcase
        modelPc = nextPc;
    endfunction

endpackage

//--- hw/mipsSubsystem.sv
//============================================================================
// core top level, exposes one instruction and one data wishbone master
// ResetVector must be word aligned
//============================================================================
`timescale 1ns/1ps

module mipsSubsystem #(
    parameter cpuPkg::wordT ResetVector = 32'h0000_0000
) (
    input  logic         clk,
    input  logic         rstN,
    output logic         iCyc,
    output logic         iStb,
    output cpuPkg::wordT iAdr,
    input  cpuPkg::wordT iDatIn,
    input  logic         iAck,
    output logic         dCyc,
    output logic         dStb,
    output logic         dWe,
    output cpuPkg::wordT dAdr,
    output cpuPkg::wordT dDatOut,
    input  cpuPkg::wordT dDatIn,
    input  logic         dAck
);
    import cpuPkg::*;

    logic    decodeEn;
    opcodeT  op;
    functT   funct;
    logic    regWrite;
    logic    aluSrc;
    logic    memWrite;
    logic    memRead;
    logic    memToReg;
    logic    branch;
    logic    jump;
    logic    regDst;
    logic    jalSelect;
    logic    jumpReg;
    aluOpT   aluOp;
    regAddrT rdAddr1;
    regAddrT rdAddr2;
    regAddrT wrAddr;
    wordT    wrData;
    logic    regWe;
    wordT    rdData1;
    wordT    rdData2;
    wordT    aluA;
    wordT    aluB;
    wordT    aluY;
    logic    aluZero;

    coreSequencer #(
        .ResetVector(ResetVector)
    ) i_coreSequencer (
        .*                          // port names match the nets above
    );

    controlDecoder i_controlDecoder (
        .clk      (clk),
        .rstN     (rstN),
        .en       (decodeEn),
        .op       (op),
        .funct    (funct),
        .regWrite (regWrite),
        .aluSrc   (aluSrc),
        .memWrite (memWrite),
        .memRead  (memRead),
        .memToReg (memToReg),
        .branch   (branch),
        .jump     (jump),
        .regDst   (regDst),
        .jalSelect(jalSelect),
        .jumpReg  (jumpReg),
        .aluOp    (aluOp)
    );

    regFile i_regFile (
        .clk    (clk),
        .rstN   (rstN),
        .we     (regWe),
        .rdAddr1(rdAddr1),
        .rdAddr2(rdAddr2),
        .wrAddr (wrAddr),
        .wrData (wrData),
        .rdData1(rdData1),
        .rdData2(rdData2)
    );

    aluUnit i_aluUnit (
        .a   (aluA),
        .b   (aluB),
        .op  (aluOp),
        .y   (aluY),
        .zero(aluZero)
    );

endmodule

//--- hw/coreSequencer.sv
//============================================================================
// multicycle control, no delay slot, pc updates at the end of execute
// both bus ports are wishbone classic, full words only
//============================================================================
`timescale 1ns/1ps

module coreSequencer #(
    parameter cpuPkg::wordT ResetVector = 32'h0000_0000
) (
    input  logic            clk,
    input  logic            rstN,
    // instruction port, read only
    output logic            iCyc,
    output logic            iStb,
    output cpuPkg::wordT    iAdr,
    input  cpuPkg::wordT    iDatIn,
    input  logic            iAck,
    // data port
    output logic            dCyc,
    output logic            dStb,
    output logic            dWe,
    output cpuPkg::wordT    dAdr,
    output cpuPkg::wordT    dDatOut,
    input  cpuPkg::wordT    dDatIn,
    input  logic            dAck,
    // decoder
    output logic            decodeEn,
    output cpuPkg::opcodeT  op,
    output cpuPkg::functT   funct,
    input  logic            regWrite,
    input  logic            aluSrc,
    input  logic            memWrite,
    input  logic            memRead,
    input  logic            memToReg,
    input  logic            branch,
    input  logic            jump,
    input  logic            regDst,
    input  logic            jalSelect,
    input  logic            jumpReg,
    // register file
    output cpuPkg::regAddrT rdAddr1,
    output cpuPkg::regAddrT rdAddr2,
    output cpuPkg::regAddrT wrAddr,
    output cpuPkg::wordT    wrData,
    output logic            regWe,
    input  cpuPkg::wordT    rdData1,
    input  cpuPkg::wordT    rdData2,
    // alu
    output cpuPkg::wordT    aluA,
    output cpuPkg::wordT    aluB,
    input  cpuPkg::wordT    aluY,
    input  logic            aluZero
);
    import cpuPkg::*;

    seqStateT state;
    wordT     pc;
    wordT     ir;               // instruction register
    logic     fetchActive;      // drives iCyc and iStb
    logic     dataActive;       // drives dCyc and dStb
    logic     memAccess;        // lw or sw
    wordT     pcPlus4;
    wordT     immSext;
    wordT     immZext;
    wordT     branchTarget;
    wordT     jumpTarget;
    wordT     nextPc;

    // instruction fields
    assign op      = ir[31:26];
    assign funct   = ir[5:0];
    assign rdAddr1 = ir[25:21];     // rs
    assign rdAddr2 = ir[20:16];     // rt

    assign decodeEn  = (state == Decode);
    assign memAccess = memRead | memWrite;

    assign iCyc = fetchActive;
    assign iStb = fetchActive;
    assign iAdr = pc;
    assign dCyc = dataActive;
    assign dStb = dataActive;

    // operand b select
    assign immSext = {{16{ir[15]}}, ir[15:0]};
    assign immZext = {16'd0, ir[15:0]};
    assign aluA    = rdData1;

    always_comb begin
        if (!aluSrc) begin
            aluB = rdData2;         // r-type and bne use rt
        end else if (memAccess) begin
            aluB = immSext;         // load/store offset
        end else begin
            aluB = immZext;         // xori
        end
    end

    // next pc resolution, used in execute
    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pcPlus4 + {immSext[29:0], 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], ir[25:0], 2'b00};

    always_comb begin
        if (jumpReg) begin
            nextPc = {rdData1[31:2], 2'b00};    // jr clears low bits
        end else if (jump) begin
            nextPc = jumpTarget;
        end else if (branch && !aluZero) begin
            nextPc = branchTarget;              // bne taken
        end else begin
            nextPc = pcPlus4;
        end
    end

    // write back selects
    always_comb begin
        if (jalSelect) begin
            wrAddr = 5'd31;         // link register
        end else if (regDst) begin
            wrAddr = ir[15:11];     // rd
        end else begin
            wrAddr = ir[20:16];     // rt
        end
    end

    always_comb begin
        if (memToReg) begin
            wrData = dDatIn;        // load data on ack
        end else if (jalSelect) begin
            wrData = pcPlus4;       // return address
        end else begin
            wrData = aluY;
        end
    end

    // alu results written at end of execute, loads on the data ack
    assign regWe = ((state == Execute) && regWrite && !memRead)
                || ((state == Memory) && memRead && dAck);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state       <= Fetch;
            pc          <= ResetVector;
            fetchActive <= 1'b0;
            dataActive  <= 1'b0;
            dWe         <= 1'b0;
        end else begin
            case (state)
                Fetch: begin
                    if (!fetchActive) begin
                        fetchActive <= 1'b1;    // only right after reset
                    end else if (iAck) begin
                        fetchActive <= 1'b0;
                        state       <= Decode;
                    end
                end
                Decode: begin
                    state <= Execute;           // decoder latches now
                end
                Execute: begin
                    pc <= nextPc;
                    if (memAccess) begin
                        dataActive <= 1'b1;
                        dWe        <= memWrite;
                        state      <= Memory;
                    end else begin
                        fetchActive <= 1'b1;    // next fetch starts at once
                        state       <= Fetch;
                    end
                end
                Memory: begin
                    if (dAck) begin
                        dataActive  <= 1'b0;
                        dWe         <= 1'b0;
                        fetchActive <= 1'b1;
                        state       <= Fetch;
                    end
                end
                default: state <= Fetch;
            endcase
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if ((state == Fetch) && fetchActive && iAck) begin
            ir <= iDatIn;
        end
        if ((state == Execute) && memAccess) begin
            dAdr    <= aluY;        // held through the data cycle
            dDatOut <= rdData2;     // rt for sw
        end
    end

endmodule

//--- hw/controlDecoder.sv
//============================================================================
// registered decode, outputs update only on the edge where en is high
// unknown opcode or function gives all zeros, a no-op
//============================================================================
`timescale 1ns/1ps

module controlDecoder (
    input  logic           clk,
    input  logic           rstN,
    input  logic           en,         // high during decode step
    input  cpuPkg::opcodeT op,
    input  cpuPkg::functT  funct,
    output logic           regWrite,
    output logic           aluSrc,
    output logic           memWrite,
    output logic           memRead,
    output logic           memToReg,
    output logic           branch,
    output logic           jump,
    output logic           regDst,
    output logic           jalSelect,
    output logic           jumpReg,
    output cpuPkg::aluOpT  aluOp
);
    import cpuPkg::*;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            regWrite  <= 1'b0;
            aluSrc    <= 1'b0;
            memWrite  <= 1'b0;
            memRead   <= 1'b0;
            memToReg  <= 1'b0;
            branch    <= 1'b0;
            jump      <= 1'b0;
            regDst    <= 1'b0;
            jalSelect <= 1'b0;
            jumpReg   <= 1'b0;
            aluOp     <= AluAdd;
        end else if (en) begin
            regWrite  <= 1'b0;      // defaults form a no-op
            aluSrc    <= 1'b0;
            memWrite  <= 1'b0;
            memRead   <= 1'b0;
            memToReg  <= 1'b0;
            branch    <= 1'b0;
            jump      <= 1'b0;
            regDst    <= 1'b0;
            jalSelect <= 1'b0;
            jumpReg   <= 1'b0;
            aluOp     <= AluAdd;
            case (op)
                OpLw: begin
                    regWrite <= 1'b1;       // load into rt
                    aluSrc   <= 1'b1;       // rs + sign ext offset
                    memRead  <= 1'b1;
                    memToReg <= 1'b1;       // write back bus data
                end
                OpSw: begin
                    aluSrc   <= 1'b1;       // rs + sign ext offset
                    memWrite <= 1'b1;       // rt goes out on dDatOut
                end
                OpJ: begin
                    jump <= 1'b1;           // pseudo direct target
                end
                OpJal: begin
                    jump      <= 1'b1;
                    regWrite  <= 1'b1;      // link into r31
                    jalSelect <= 1'b1;      // r31 and pc+4
                end
                OpBne: begin
                    branch <= 1'b1;
                    aluOp  <= AluSub;       // zero flag means equal
                end
                OpXori: begin
                    regWrite <= 1'b1;       // result into rt
                    aluSrc   <= 1'b1;       // zero ext immediate
                    aluOp    <= AluXor;
                end
                OpRType: begin
                    case (funct)
                        FnJr: begin
                            jump    <= 1'b1;
                            jumpReg <= 1'b1;    // target from rs, no write
                        end
                        FnAdd: begin
                            regWrite <= 1'b1;
                            regDst   <= 1'b1;   // rd
                        end
                        FnSub: begin
                            regWrite <= 1'b1;
                            regDst   <= 1'b1;
                            aluOp    <= AluSub;
                        end
                        FnSlt: begin
                            regWrite <= 1'b1;
                            regDst   <= 1'b1;
                            aluOp    <= AluSlt;
                        end
                        default: ;              // keep no-op defaults
                    endcase
                end
                default: ;                      // unsupported opcode
            endcase
        end
    end

endmodule

//--- hw/regFile.sv
//============================================================================
// 32x32 registers, async read and sync write, r0 hardwired to zero
//============================================================================
`timescale 1ns/1ps

module regFile (
    input  logic            clk,
    input  logic            rstN,
    input  logic            we,
    input  cpuPkg::regAddrT rdAddr1,
    input  cpuPkg::regAddrT rdAddr2,
    input  cpuPkg::regAddrT wrAddr,
    input  cpuPkg::wordT    wrData,
    output cpuPkg::wordT    rdData1,
    output cpuPkg::wordT    rdData2
);
    import cpuPkg::*;

    wordT regs [1:31];      // no storage for r0

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wrAddr != '0)) begin
            regs[wrAddr] <= wrData;     // r0 writes dropped
        end
    end

    assign rdData1 = (rdAddr1 == '0) ? '0 : regs[rdAddr1];
    assign rdData2 = (rdAddr2 == '0) ? '0 : regs[rdAddr2];

endmodule

//--- hw/aluUnit.sv
//============================================================================
// combinational alu, slt compares signed and returns 0 or 1
//============================================================================
`timescale 1ns/1ps

module aluUnit (
    input  cpuPkg::wordT  a,
    input  cpuPkg::wordT  b,
    input  cpuPkg::aluOpT op,
    output cpuPkg::wordT  y,
    output logic          zero
);
    import cpuPkg::*;

    logic lessThan;     // signed a < b

    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            AluAdd:  y = a + b;
            AluSub:  y = a - b;
            AluXor:  y = a ^ b;
            AluSlt:  y = {31'd0, lessThan};
            AluAnd:  y = a & b;
            AluNand: y = ~(a & b);
            AluNor:  y = ~(a | b);
            AluOr:   y = a | b;
            default: y = '0;
        endcase
    end

    assign zero = (y == '0);    // bne tests this after sub

endmodule

//--- hw/cpuPkg.sv
//============================================================================
// types and encodings for the MIPS-I subset core, word accesses only
// opcodes and functions not listed here decode as no-ops
//============================================================================
package cpuPkg;

    typedef logic [31:0] wordT;     // data or address word
    typedef logic [4:0]  regAddrT;  // register index
    typedef logic [5:0]  opcodeT;   // primary opcode field
    typedef logic [5:0]  functT;    // r-type function field
    typedef logic [2:0]  aluOpT;    // alu operation select

    // primary opcodes
    localparam opcodeT OpRType = 6'h00;
    localparam opcodeT OpJ     = 6'h02;
    localparam opcodeT OpJal   = 6'h03;
    localparam opcodeT OpBne   = 6'h05;
    localparam opcodeT OpXori  = 6'h0E;
    localparam opcodeT OpLw    = 6'h23;
    localparam opcodeT OpSw    = 6'h2B;

    // function codes under OpRType
    localparam functT FnJr  = 6'h08;
    localparam functT FnAdd = 6'h20;
    localparam functT FnSub = 6'h22;
    localparam functT FnSlt = 6'h2A;

    // alu operations
    localparam aluOpT AluAdd  = 3'd0;
    localparam aluOpT AluSub  = 3'd1;
    localparam aluOpT AluXor  = 3'd2;
    localparam aluOpT AluSlt  = 3'd3;
    localparam aluOpT AluAnd  = 3'd4;
    localparam aluOpT AluNand = 3'd5;
    localparam aluOpT AluNor  = 3'd6;
    localparam aluOpT AluOr   = 3'd7;

    // sequencer steps, memory only for lw and sw
    typedef enum logic [1:0] {
        Fetch,      // instruction bus cycle
        Decode,     // controls registered
        Execute,    // alu and next pc
        Memory      // data bus cycle
    } seqStateT;

endpackage
